//--- Bender.yml
package:
  name: fetch_decode

sources:
  - files:
      - rv_decode_pkg.sv
      - fetch_control.sv
      - pc_counter.sv
      - inst_reg_decode.sv
      - fetch_decode_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fetch_decode.sv

//--- fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
	input  logic clk,
	input  logic reset,
	input  logic mem_valid,
	input  logic advance,
	input  logic redirect,
	output logic mem_rd,
	output logic ir_wr,
	output logic dec_valid,
	output logic pc_step,
	output logic pc_load
);

	rv_decode_pkg::fetch_state_t state;
	rv_decode_pkg::fetch_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			rv_decode_pkg::fetch: state_next = rv_decode_pkg::wait_mem;
			rv_decode_pkg::wait_mem: begin
				if (mem_valid)
					state_next = rv_decode_pkg::decode;
			end
			rv_decode_pkg::decode: state_next = rv_decode_pkg::exec_wait;
			rv_decode_pkg::exec_wait: begin
				if (advance) // execute done with this word
					state_next = rv_decode_pkg::fetch;
			end
			default: state_next = rv_decode_pkg::fetch;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= rv_decode_pkg::fetch;
		else
			state <= state_next;
	end

	// read request held off until reset is released
	assign mem_rd = (state == rv_decode_pkg::fetch) && !reset;
	assign ir_wr = (state == rv_decode_pkg::wait_mem) && mem_valid;
	assign dec_valid = (state == rv_decode_pkg::decode);
	assign pc_step = (state == rv_decode_pkg::decode); // pc moves at end of decode
	assign pc_load = (state == rv_decode_pkg::exec_wait) && advance && redirect;

	// single outstanding read
	a_rd_single: assert property (
		@(posedge clk) disable iff (reset)
		mem_rd |=> !mem_rd
	);

	a_dec_then_wait: assert property (
		@(posedge clk) disable iff (reset)
		dec_valid |=> (state == rv_decode_pkg::exec_wait)
	);

endmodule

`default_nettype wire

//--- fetch_decode_top.f
+incdir+.
rv_decode_pkg.sv
fetch_control.sv
pc_counter.sv
inst_reg_decode.sv
fetch_decode_top.sv
tb_fetch_decode.sv

//--- fetch_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_top #(
	parameter int ADDR_W = 32,
	parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
	input  logic clk,
	input  logic reset,
	output logic mem_rd,
	output logic [ADDR_W-1:0] mem_addr,
	input  logic [31:0] mem_rdata,
	input  logic mem_valid,
	output logic dec_valid,
	output rv_decode_pkg::decoded_t dec,
	output logic [ADDR_W-1:0] dec_pc,
	input  logic advance,
	input  logic redirect,
	input  logic [ADDR_W-1:0] redirect_pc
);

	logic ir_wr;
	logic pc_step;
	logic pc_load;
	logic [ADDR_W-1:0] pc;

	fetch_control u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.mem_valid (mem_valid),
		.advance   (advance),
		.redirect  (redirect),
		.mem_rd    (mem_rd),
		.ir_wr     (ir_wr),
		.dec_valid (dec_valid),
		.pc_step   (pc_step),
		.pc_load   (pc_load)
	);

	pc_counter #(
		.ADDR_W   (ADDR_W),
		.RESET_PC (RESET_PC)
	) u_pc (
		.clk         (clk),
		.reset       (reset),
		.pc_step     (pc_step),
		.pc_load     (pc_load),
		.dec         (dec),
		.redirect_pc (redirect_pc),
		.pc          (pc),
		.dec_pc      (dec_pc)
	);

	inst_reg_decode u_dec (
		.clk       (clk),
		.ir_wr     (ir_wr),
		.mem_rdata (mem_rdata),
		.dec       (dec)
	);

	assign mem_addr = pc; // fetch always from current pc

endmodule

`default_nettype wire

//--- inst_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_reg_decode (
	input  logic clk,
	input  logic ir_wr,
	input  logic [31:0] mem_rdata,
	output rv_decode_pkg::decoded_t dec
);

	logic [31:0] ir;
	rv_decode_pkg::inst_class_t cls;
	logic [9:0] funct;
	logic [31:0] imm;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [11:0] imm_i;
	logic [11:0] imm_s;
	logic [12:1] imm_b;
	logic [20:1] imm_j;
	logic [31:12] imm_u;

	always_ff @(posedge clk) begin
		if (ir_wr)
			ir <= mem_rdata;
	end

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	// immediate fields, scrambled per format
	assign imm_i = ir[31:20];
	assign imm_s = {ir[31:25], ir[11:7]};
	assign imm_b = {ir[31], ir[7], ir[30:25], ir[11:8]};
	assign imm_j = {ir[31], ir[19:12], ir[20], ir[30:21]};
	assign imm_u = ir[31:12];

	always_comb begin
		cls = '0;
		case (opcode)
			rv_decode_pkg::op_lui:       cls.lui = 1'b1;
			rv_decode_pkg::op_auipc:     cls.auipc = 1'b1;
			rv_decode_pkg::op_jal:       cls.jal = 1'b1;
			rv_decode_pkg::op_jalr:      cls.jalr = 1'b1;
			rv_decode_pkg::op_branch:    cls.branch = 1'b1;
			rv_decode_pkg::op_load:      cls.load = 1'b1;
			rv_decode_pkg::op_store:     cls.store = 1'b1;
			rv_decode_pkg::op_arlog_imm: cls.arlog_imm = 1'b1;
			rv_decode_pkg::op_arlog:     cls.arlog = 1'b1;
			rv_decode_pkg::op_misc_mem:  cls.misc_mem = 1'b1;
			rv_decode_pkg::op_system:    cls.system = 1'b1;
			default: ; // unknown opcode, no class
		endcase
	end

	always_comb begin
		funct = {7'b0, funct3};
		if (cls.arlog)
			funct[9:3] = funct7;
		else if (cls.arlog_imm && (funct3 == 3'b001 || funct3 == 3'b101))
			funct[9:3] = funct7; // shifts keep funct7
	end

	always_comb begin
		imm = 32'b0;
		if (cls.lui || cls.auipc)
			imm = {imm_u, 12'b0};
		else if (cls.jal)
			imm = {{11{imm_j[20]}}, imm_j, 1'b0};
		else if (cls.jalr || cls.load || cls.arlog_imm || cls.system)
			imm = {{20{imm_i[11]}}, imm_i};
		else if (cls.branch)
			imm = {{19{imm_b[12]}}, imm_b, 1'b0};
		else if (cls.store)
			imm = {{20{imm_s[11]}}, imm_s};
	end

	assign dec = '{
		cls:   cls,
		funct: funct,
		rd:    ir[11:7],
		rs1:   ir[19:15],
		rs2:   ir[24:20],
		imm:   imm
	};

	// checked once a word has been loaded
	a_cls_onehot: assert property (
		@(posedge clk)
		ir_wr |=> $onehot0(dec.cls)
	);

endmodule

`default_nettype wire

//--- pc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module pc_counter #(
	parameter int ADDR_W = 32,
	parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic pc_step,
	input  logic pc_load,
	input  rv_decode_pkg::decoded_t dec,
	input  logic [ADDR_W-1:0] redirect_pc,
	output logic [ADDR_W-1:0] pc,
	output logic [ADDR_W-1:0] dec_pc
);

	logic [ADDR_W-1:0] offset;
	logic [ADDR_W-1:0] dec_pc_q;

	// jal jumps relative to its own address
	assign offset = dec.cls.jal ? ADDR_W'(signed'(dec.imm)) : ADDR_W'(4);

	always_ff @(posedge clk) begin
		if (reset)
			pc <= RESET_PC;
		else if (pc_load)
			pc <= redirect_pc; // redirect wins over any step
		else if (pc_step)
			pc <= pc + offset;
	end

	// address of the word now in decode, held through exec_wait
	always_ff @(posedge clk) begin
		if (pc_step)
			dec_pc_q <= pc;
	end

	assign dec_pc = pc_step ? pc : dec_pc_q; // pc still points at the word during decode

	a_step_load_excl: assert property (
		@(posedge clk) disable iff (reset)
		!(pc_step && pc_load)
	);

endmodule

`default_nettype wire

//--- rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

	// RV32I major opcodes
	localparam logic [6:0] op_lui       = 7'b0110111;
	localparam logic [6:0] op_auipc     = 7'b0010111;
	localparam logic [6:0] op_jal       = 7'b1101111;
	localparam logic [6:0] op_jalr      = 7'b1100111;
	localparam logic [6:0] op_branch    = 7'b1100011;
	localparam logic [6:0] op_load      = 7'b0000011;
	localparam logic [6:0] op_store     = 7'b0100011;
	localparam logic [6:0] op_arlog_imm = 7'b0010011;
	localparam logic [6:0] op_arlog     = 7'b0110011;
	localparam logic [6:0] op_misc_mem  = 7'b0001111;
	localparam logic [6:0] op_system    = 7'b1110011;

	// one flag per opcode class, all low for an unknown opcode
	typedef struct packed {
		logic lui;
		logic auipc;
		logic jal;
		logic jalr;
		logic branch;
		logic load;
		logic store;
		logic arlog_imm;
		logic arlog;
		logic misc_mem;
		logic system;
	} inst_class_t;

	typedef struct packed {
		inst_class_t cls;
		logic [9:0]  funct; // funct7 above funct3
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;   // sign-extended
	} decoded_t;

	typedef enum logic [1:0] {
		fetch,
		wait_mem,
		decode,
		exec_wait
	} fetch_state_t;

endpackage

`default_nettype wire

//--- tb_fetch_decode_vectors.svh
// columns: word, mem latency, redirect, redirect_pc, class, funct, rd, rs1, rs2, imm, fetch addr
// class bits run from lui (bit 10) down to system (bit 0)
localparam int num_vecs = 16;

vec_t vec_tab [num_vecs];

task automatic fill_table();
	vec_tab[0] = '{32'hffff_f0b7, 3'd1, 1'b0, 32'h0000_0000,
		11'h400, 10'h007, 5'h01, 5'h1f, 5'h1f, 32'hffff_f000, 32'h0000_1000}; // lui
	vec_tab[1] = '{32'h1234_5117, 3'd2, 1'b0, 32'h0000_0000,
		11'h200, 10'h005, 5'h02, 5'h08, 5'h03, 32'h1234_5000, 32'h0000_1004}; // auipc
	vec_tab[2] = '{32'h4020_81b3, 3'd3, 1'b0, 32'h0000_0000,
		11'h004, 10'h100, 5'h03, 5'h01, 5'h02, 32'h0000_0000, 32'h0000_1008}; // sub
	vec_tab[3] = '{32'h4032_d213, 3'd4, 1'b0, 32'h0000_0000,
		11'h008, 10'h105, 5'h04, 5'h05, 5'h03, 32'h0000_0403, 32'h0000_100c}; // srai
	vec_tab[4] = '{32'hffb3_8313, 3'd1, 1'b0, 32'h0000_5550,
		11'h008, 10'h000, 5'h06, 5'h07, 5'h1b, 32'hffff_fffb, 32'h0000_1010}; // addi -5
	vec_tab[5] = '{32'hff04_a403, 3'd2, 1'b0, 32'h0000_0000,
		11'h020, 10'h002, 5'h08, 5'h09, 5'h10, 32'hffff_fff0, 32'h0000_1014}; // lw
	vec_tab[6] = '{32'hfea5_a623, 3'd3, 1'b0, 32'h0000_0000,
		11'h010, 10'h002, 5'h0c, 5'h0b, 5'h0a, 32'hffff_ffec, 32'h0000_1018}; // sw
	vec_tab[7] = '{32'hfed6_0ce3, 3'd4, 1'b1, 32'h0000_2000,
		11'h040, 10'h000, 5'h19, 5'h0c, 5'h0d, 32'hffff_fff8, 32'h0000_101c}; // beq taken
	vec_tab[8] = '{32'h1000_00ef, 3'd1, 1'b0, 32'h0000_0000,
		11'h100, 10'h000, 5'h01, 5'h00, 5'h00, 32'h0000_0100, 32'h0000_2000}; // jal +256
	vec_tab[9] = '{32'hff5f_f06f, 3'd2, 1'b0, 32'h0000_7000,
		11'h100, 10'h007, 5'h00, 5'h1f, 5'h15, 32'hffff_fff4, 32'h0000_2100}; // jal -12
	vec_tab[10] = '{32'h0080_016f, 3'd3, 1'b1, 32'h0000_3000,
		11'h100, 10'h000, 5'h02, 5'h00, 5'h08, 32'h0000_0008, 32'h0000_20f4}; // jal, redirected
	vec_tab[11] = '{32'hffc2_80e7, 3'd4, 1'b1, 32'h0000_3400,
		11'h080, 10'h000, 5'h01, 5'h05, 5'h1c, 32'hffff_fffc, 32'h0000_3000}; // jalr
	vec_tab[12] = '{32'h0ff0_000f, 3'd1, 1'b0, 32'h0000_0000,
		11'h002, 10'h000, 5'h00, 5'h00, 5'h1f, 32'h0000_0000, 32'h0000_3400}; // fence
	vec_tab[13] = '{32'hf140_21f3, 3'd2, 1'b0, 32'h0000_0000,
		11'h001, 10'h002, 5'h03, 5'h00, 5'h14, 32'hffff_ff14, 32'h0000_3404}; // csrrs
	vec_tab[14] = '{32'hffff_ffff, 3'd3, 1'b0, 32'h0000_0000,
		11'h000, 10'h007, 5'h1f, 5'h1f, 5'h1f, 32'h0000_0000, 32'h0000_3408}; // unknown
	vec_tab[15] = '{32'h01f5_1493, 3'd4, 1'b0, 32'h0000_0000,
		11'h008, 10'h001, 5'h09, 5'h0a, 5'h1f, 32'h0000_001f, 32'h0000_340c}; // slli
endtask

//--- tb_fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_decode;

	localparam int max_wait = 5; // extra cycles in exec_wait

	typedef struct packed {
		logic [31:0] word;
		logic [2:0]  lat;
		logic        redir;
		logic [31:0] redir_pc;
		rv_decode_pkg::inst_class_t cls;
		logic [9:0]  funct;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic [31:0] addr;
	} vec_t;

	logic clk;
	logic reset;
	logic mem_rd;
	logic [31:0] mem_addr;
	logic [31:0] mem_rdata;
	logic mem_valid;
	logic dec_valid;
	rv_decode_pkg::decoded_t dec;
	logic [31:0] dec_pc;
	logic advance;
	logic redirect;
	logic [31:0] redirect_pc;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 1000;

	`include "tb_fetch_decode_vectors.svh"

	fetch_decode_top #(
		.ADDR_W   (32),
		.RESET_PC (32'h0000_1000)
	) DUT (
		.clk         (clk),
		.reset       (reset),
		.mem_rd      (mem_rd),
		.mem_addr    (mem_addr),
		.mem_rdata   (mem_rdata),
		.mem_valid   (mem_valid),
		.dec_valid   (dec_valid),
		.dec         (dec),
		.dec_pc      (dec_pc),
		.advance     (advance),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run stopped after %0d cycles in state %s",
				cycles, DUT.u_ctrl.state.name());
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: expected %h, got %h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic wait_mem_read();
		do
			@(posedge clk);
		while (mem_rd !== 1'b1);
	endtask

	// memory side: latency, one valid pulse, then dec_valid one cycle later
	task automatic serve_word(input vec_t v);
		int gap;
		repeat (v.lat - 1) begin
			@(posedge clk);
			check_val("mem_rd", {31'b0, mem_rd}, 32'h0);
		end
		@(negedge clk);
		mem_valid = 1'b1;
		mem_rdata = v.word;
		@(posedge clk);
		check_val("mem_rd", {31'b0, mem_rd}, 32'h0);
		@(negedge clk);
		mem_valid = 1'b0;
		mem_rdata = ~v.word; // ir must not follow the bus
		gap = 0;
		do begin
			@(posedge clk);
			gap++;
		end while (dec_valid !== 1'b1);
		check_val("dec_valid delay", gap, 32'd1);
	endtask

	task automatic check_decode(input vec_t v);
		check_val("dec.cls", {21'b0, dec.cls}, {21'b0, v.cls});
		check_val("dec.funct", {22'b0, dec.funct}, {22'b0, v.funct});
		check_val("dec.rd", {27'b0, dec.rd}, {27'b0, v.rd});
		check_val("dec.rs1", {27'b0, dec.rs1}, {27'b0, v.rs1});
		check_val("dec.rs2", {27'b0, dec.rs2}, {27'b0, v.rs2});
		check_val("dec.imm", dec.imm, v.imm);
		check_val("dec_pc", dec_pc, v.addr);
	endtask

	task automatic check_hold(input vec_t v);
		check_decode(v);
		check_val("mem_rd", {31'b0, mem_rd}, 32'h0);
		check_val("dec_valid", {31'b0, dec_valid}, 32'h0);
	endtask

	task automatic hold_and_advance(input vec_t v, input int waits);
		@(posedge clk); // first cycle of exec_wait
		check_hold(v);
		repeat (waits) begin
			@(posedge clk);
			check_hold(v);
		end
		@(negedge clk);
		advance = 1'b1;
		redirect = v.redir;
		redirect_pc = v.redir_pc;
		@(posedge clk);
		check_hold(v);
		@(negedge clk);
		advance = 1'b0;
		redirect = 1'b0;
		redirect_pc = 32'hffff_fffc;
	endtask

	initial begin
		vec_t v;
		int waits;
		reset = 1'b1;
		mem_rdata = '0;
		mem_valid = 1'b0;
		advance = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		void'($urandom(32'h275f_2735));
		fill_table();
		cycle_limit = 3;
		for (int i = 0; i < num_vecs; i++)
			cycle_limit += vec_tab[i].lat + max_wait + 20;
		repeat (3) begin
			@(negedge clk);
			check_val("mem_rd", {31'b0, mem_rd}, 32'h0);
			check_val("dec_valid", {31'b0, dec_valid}, 32'h0);
		end
		reset = 1'b0;
		for (int i = 0; i < num_vecs; i++) begin
			v = vec_tab[i];
			waits = $urandom % (max_wait + 1);
			wait_mem_read();
			check_val("mem_addr", mem_addr, v.addr);
			serve_word(v);
			check_decode(v);
			hold_and_advance(v, waits);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
